// ==== include/vd_config.svh ====
`ifndef VD_CONFIG_SVH
`define VD_CONFIG_SVH

// Generator masks over {input, state}, octal 17 and 15
`define VD_G0 4'b1111
`define VD_G1 4'b1101

// Symbols per traceback block
`define VD_BLOCK_LEN 16

// Address width of one survivor bank
`define VD_ADDR_W 4

// Rotating survivor banks
`define VD_BANKS 4

// Path metric width
`define VD_METRIC_W 8

`endif

// ==== design/vd_pkg.sv ====
`include "vd_config.svh"

package vd_pkg;

   // Received symbol, bit 0 is c0 and bit 1 is c1
   typedef logic [1:0] sym_t;

   // Hamming distance 0..2
   typedef logic [1:0] bm_t;

   // One distance per code word
   typedef bm_t [3:0] bm_vec_t;

   typedef logic [`VD_METRIC_W-1:0] metric_t;

   // Bit 2 holds the newest input bit
   typedef logic [2:0] state_t;

   // One survivor decision per state
   typedef logic [7:0] dec_word_t;

   typedef logic [1:0] bank_t;

   // Code word emitted when input bit u leaves state s
   function automatic sym_t code_word(input logic u, input state_t s);
      logic [3:0] r;
      r = {u, s};
      return {^(r & `VD_G1), ^(r & `VD_G0)};
   endfunction

endpackage

// ==== design/vd_mem_rd_if.sv ====
`timescale 1ns/1ps
`include "vd_config.svh"

interface vd_mem_rd_if;
   import vd_pkg::*;

   logic                  rd_en;
   bank_t                 rd_bank;
   logic [`VD_ADDR_W-1:0] rd_addr;
   // Valid one cycle after the read
   dec_word_t             rd_data;

   modport master (output rd_en, output rd_bank, output rd_addr, input rd_data);

   modport slave (input rd_en, input rd_bank, input rd_addr, output rd_data);

endinterface

// ==== design/vd_ram.sv ====
`timescale 1ns/1ps

module vd_ram #(
   parameter type word_t = logic,
   parameter int  DEPTH  = 16
) (
   input  logic                     clk,
   input  logic                     wr_i,
   input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
   input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
   input  word_t                    wr_data_i,
   output word_t                    rd_data_o
);

   word_t mem [DEPTH];

   // Read-first, a write to the read address shows up a cycle later
   always_ff @(posedge clk)
   begin
      if (wr_i)
         mem[wr_addr_i] <= wr_data_i;
      rd_data_o <= mem[rd_addr_i];
   end

endmodule

// ==== design/vd_branch_metric.sv ====
`timescale 1ns/1ps

module vd_branch_metric (
   input  logic            clk,
   input  logic            rst,
   input  vd_pkg::sym_t    sym_i,
   output vd_pkg::bm_vec_t bm_o,
   output logic            bm_valid_o
);
   import vd_pkg::*;

   sym_t sym_q;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         bm_valid_o <= 1'b0;
      else
         bm_valid_o <= 1'b1;
   end

   always_ff @(posedge clk)
      sym_q <= sym_i;

   // Hamming distance to each code word
   for (genvar cw = 0; cw < 4; cw++)
   begin : g_dist
      localparam sym_t CW = sym_t'(cw);
      sym_t diff;

      assign diff     = sym_q ^ CW;
      assign bm_o[cw] = bm_t'(diff[0]) + bm_t'(diff[1]);
   end

endmodule

// ==== design/vd_acs_array.sv ====
`timescale 1ns/1ps
`include "vd_config.svh"

module vd_acs_array (
   input  logic              clk,
   input  logic              rst,
   input  vd_pkg::bm_vec_t   bm_i,
   input  logic              bm_valid_i,
   output vd_pkg::dec_word_t dec_o,
   output logic              dec_valid_o
);
   import vd_pkg::*;

   localparam int NUM_STATES = $bits(dec_word_t);
   localparam int TOP        = `VD_METRIC_W - 1;

   metric_t                 pm_q [NUM_STATES];
   metric_t                 pm_d [NUM_STATES];
   logic [NUM_STATES-1:0]   reach_q;
   logic [NUM_STATES-1:0]   reach_d;
   logic [NUM_STATES-1:0]   top_set;
   dec_word_t               dec_d;
   logic                    norm;

   for (genvar n = 0; n < NUM_STATES; n++)
   begin : g_state
      // Predecessors differ only in their lowest bit
      localparam int   P0  = 2 * (n % (NUM_STATES / 2));
      localparam int   P1  = P0 + 1;
      localparam sym_t CW0 = code_word(1'(n / (NUM_STATES / 2)), state_t'(P0));
      localparam sym_t CW1 = code_word(1'(n / (NUM_STATES / 2)), state_t'(P1));
      metric_t sum0;
      metric_t sum1;
      logic    pick1;

      assign sum0 = pm_q[P0] + metric_t'(bm_i[CW0]);
      assign sum1 = pm_q[P1] + metric_t'(bm_i[CW1]);

      // Unreached predecessor never wins, ties go to P0
      assign pick1 = !reach_q[P0] || (reach_q[P1] && (sum1 < sum0));

      assign dec_d[n]   = pick1;
      assign pm_d[n]    = pick1 ? sum1 : sum0;
      assign reach_d[n] = reach_q[P0] | reach_q[P1];
      assign top_set[n] = !reach_d[n] || pm_d[n][TOP];
   end

   // All live metrics past half range
   assign norm = &top_set;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         reach_q     <= NUM_STATES'(1);
         dec_valid_o <= 1'b0;
         for (int n = 0; n < NUM_STATES; n++)
            pm_q[n] <= '0;
      end
      else
      begin
         dec_valid_o <= bm_valid_i;
         if (bm_valid_i)
         begin
            reach_q <= reach_d;
            for (int n = 0; n < NUM_STATES; n++)
               pm_q[n] <= norm ? {1'b0, pm_d[n][TOP-1:0]} : pm_d[n];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (bm_valid_i)
         dec_o <= dec_d;
   end

endmodule

// ==== design/vd_survivor_mem.sv ====
`timescale 1ns/1ps
`include "vd_config.svh"

module vd_survivor_mem (
   input  logic              clk,
   input  logic              rst,
   input  vd_pkg::dec_word_t dec_i,
   input  logic              dec_valid_i,
   output logic              blk_done_o,
   output vd_pkg::bank_t     blk_bank_o,
   vd_mem_rd_if.slave        rd0,
   vd_mem_rd_if.slave        rd1
);
   import vd_pkg::*;

   logic [`VD_ADDR_W-1:0] wr_addr_q;
   bank_t                 wr_bank_q;
   logic                  primed_q;
   logic                  last_word;
   bank_t                 rd0_bank_q;
   bank_t                 rd1_bank_q;
   dec_word_t             bank_data [`VD_BANKS];

   assign last_word  = dec_valid_i && (wr_addr_q == '1);
   // The first block has no older block to decode
   assign blk_done_o = last_word && primed_q;
   assign blk_bank_o = wr_bank_q;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         wr_addr_q <= '0;
         wr_bank_q <= '0;
         primed_q  <= 1'b0;
      end
      else if (dec_valid_i)
      begin
         wr_addr_q <= wr_addr_q + `VD_ADDR_W'(1);
         if (last_word)
         begin
            wr_bank_q <= wr_bank_q + bank_t'(1);
            primed_q  <= 1'b1;
         end
      end
   end

   for (genvar k = 0; k < `VD_BANKS; k++)
   begin : g_bank
      logic                  hit0;
      logic                  hit1;
      logic [`VD_ADDR_W-1:0] rd_addr;

      assign hit0    = rd0.rd_en && (rd0.rd_bank == bank_t'(k));
      assign hit1    = rd1.rd_en && (rd1.rd_bank == bank_t'(k));
      assign rd_addr = hit0 ? rd0.rd_addr : (hit1 ? rd1.rd_addr : '0);

      vd_ram #(
         .word_t (dec_word_t),
         .DEPTH  (`VD_BLOCK_LEN)
      ) ram_inst (
         .clk       (clk),
         .wr_i      (dec_valid_i && (wr_bank_q == bank_t'(k))),
         .wr_addr_i (wr_addr_q),
         .rd_addr_i (rd_addr),
         .wr_data_i (dec_i),
         .rd_data_o (bank_data[k])
      );
   end

   always_ff @(posedge clk)
   begin
      rd0_bank_q <= rd0.rd_bank;
      rd1_bank_q <= rd1.rd_bank;
   end

   assign rd0.rd_data = bank_data[rd0_bank_q];
   assign rd1.rd_data = bank_data[rd1_bank_q];

endmodule

// ==== design/vd_traceback_unit.sv ====
`timescale 1ns/1ps
`include "vd_config.svh"

module vd_traceback_unit #(
   parameter int SLOT = 0
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  blk_done_i,
   input  vd_pkg::bank_t         blk_bank_i,
   vd_mem_rd_if.master           rd,
   output logic                  bit_o,
   output logic                  bit_wr_o,
   output logic [`VD_ADDR_W-1:0] bit_idx_o
);
   import vd_pkg::*;

   logic                  start;
   logic                  busy_q;
   logic [`VD_ADDR_W:0]   step_q;
   bank_t                 bank_q;
   logic                  rd_vld_q;
   logic                  rd_first_q;
   logic                  rd_emit_q;
   logic [`VD_ADDR_W-1:0] rd_idx_q;
   state_t                state_q;
   state_t                cur_state;

   // Units take turns on block parity
   assign start = blk_done_i && (blk_bank_i[0] == SLOT[0]);

   // Newest bank first, then the one before it, top address down
   assign rd.rd_en   = busy_q;
   assign rd.rd_bank = step_q[`VD_ADDR_W] ? bank_q - bank_t'(1) : bank_q;
   assign rd.rd_addr = ~step_q[`VD_ADDR_W-1:0];

   // Walk always starts from state 0
   assign cur_state = rd_first_q ? state_t'(0) : state_q;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         busy_q     <= 1'b0;
         step_q     <= '0;
         bank_q     <= '0;
         rd_vld_q   <= 1'b0;
         rd_first_q <= 1'b0;
         rd_emit_q  <= 1'b0;
         state_q    <= '0;
      end
      else
      begin
         if (start)
         begin
            busy_q <= 1'b1;
            step_q <= '0;
            bank_q <= blk_bank_i;
         end
         else if (busy_q)
         begin
            step_q <= step_q + (`VD_ADDR_W + 1)'(1);
            if (step_q == '1)
               busy_q <= 1'b0;
         end
         rd_vld_q   <= busy_q;
         rd_first_q <= busy_q && (step_q == '0);
         rd_emit_q  <= step_q[`VD_ADDR_W];
         if (rd_vld_q)
            state_q <= {cur_state[1:0], rd.rd_data[cur_state]};
      end
   end

   always_ff @(posedge clk)
      rd_idx_q <= ~step_q[`VD_ADDR_W-1:0];

   // Only the older block yields bits
   assign bit_o     = state_q[2];
   assign bit_wr_o  = rd_vld_q && rd_emit_q;
   assign bit_idx_o = rd_idx_q;

endmodule

// ==== design/vd_output_buf.sv ====
`timescale 1ns/1ps
`include "vd_config.svh"

module vd_output_buf (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  bit0_i,
   input  logic                  bit0_wr_i,
   input  logic [`VD_ADDR_W-1:0] bit0_idx_i,
   input  logic                  bit1_i,
   input  logic                  bit1_wr_i,
   input  logic [`VD_ADDR_W-1:0] bit1_idx_i,
   output logic                  d_out_o,
   output logic                  out_valid_o
);

   logic                  start0;
   logic                  start1;
   logic                  rd_run_q;
   logic                  rd_half_q;
   logic [`VD_ADDR_W-1:0] rd_cnt_q;
   logic                  out_half_q;
   logic                  half0_data;
   logic                  half1_data;

   // A half is complete once index 0 lands
   assign start0 = bit0_wr_i && (bit0_idx_i == '0);
   assign start1 = bit1_wr_i && (bit1_idx_i == '0);

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         rd_run_q    <= 1'b0;
         rd_half_q   <= 1'b0;
         rd_cnt_q    <= '0;
         out_valid_o <= 1'b0;
      end
      else
      begin
         if (!rd_run_q)
         begin
            if (start0 || start1)
            begin
               rd_run_q  <= 1'b1;
               rd_half_q <= start1;
            end
         end
         else
         begin
            rd_cnt_q <= rd_cnt_q + `VD_ADDR_W'(1);
            if (rd_cnt_q == '1)
               rd_half_q <= !rd_half_q;
            out_valid_o <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
      out_half_q <= rd_half_q;

   vd_ram #(
      .word_t (logic),
      .DEPTH  (`VD_BLOCK_LEN)
   ) half0_inst (
      .clk       (clk),
      .wr_i      (bit0_wr_i),
      .wr_addr_i (bit0_idx_i),
      .rd_addr_i (rd_cnt_q),
      .wr_data_i (bit0_i),
      .rd_data_o (half0_data)
   );

   vd_ram #(
      .word_t (logic),
      .DEPTH  (`VD_BLOCK_LEN)
   ) half1_inst (
      .clk       (clk),
      .wr_i      (bit1_wr_i),
      .wr_addr_i (bit1_idx_i),
      .rd_addr_i (rd_cnt_q),
      .wr_data_i (bit1_i),
      .rd_data_o (half1_data)
   );

   assign d_out_o = out_half_q ? half1_data : half0_data;

endmodule

// ==== design/vd_decoder_top.sv ====
`timescale 1ns/1ps
`include "vd_config.svh"

module vd_decoder_top (
   input  logic         clk,
   input  logic         rst,
   input  vd_pkg::sym_t d_in_i,
   output logic         d_out_o,
   output logic         out_valid_o
);
   import vd_pkg::*;

   bm_vec_t               bm;
   logic                  bm_valid;
   dec_word_t             dec;
   logic                  dec_valid;
   logic                  blk_done;
   bank_t                 blk_bank;
   logic                  tb0_bit;
   logic                  tb0_wr;
   logic [`VD_ADDR_W-1:0] tb0_idx;
   logic                  tb1_bit;
   logic                  tb1_wr;
   logic [`VD_ADDR_W-1:0] tb1_idx;

   vd_mem_rd_if rd0_if ();
   vd_mem_rd_if rd1_if ();

   vd_branch_metric bm_inst (
      .clk        (clk),
      .rst        (rst),
      .sym_i      (d_in_i),
      .bm_o       (bm),
      .bm_valid_o (bm_valid)
   );

   vd_acs_array acs_inst (
      .clk         (clk),
      .rst         (rst),
      .bm_i        (bm),
      .bm_valid_i  (bm_valid),
      .dec_o       (dec),
      .dec_valid_o (dec_valid)
   );

   vd_survivor_mem smem_inst (
      .clk         (clk),
      .rst         (rst),
      .dec_i       (dec),
      .dec_valid_i (dec_valid),
      .blk_done_o  (blk_done),
      .blk_bank_o  (blk_bank),
      .rd0         (rd0_if.slave),
      .rd1         (rd1_if.slave)
   );

   vd_traceback_unit #(.SLOT(0)) tbu0_inst (
      .clk        (clk),
      .rst        (rst),
      .blk_done_i (blk_done),
      .blk_bank_i (blk_bank),
      .rd         (rd0_if.master),
      .bit_o      (tb0_bit),
      .bit_wr_o   (tb0_wr),
      .bit_idx_o  (tb0_idx)
   );

   vd_traceback_unit #(.SLOT(1)) tbu1_inst (
      .clk        (clk),
      .rst        (rst),
      .blk_done_i (blk_done),
      .blk_bank_i (blk_bank),
      .rd         (rd1_if.master),
      .bit_o      (tb1_bit),
      .bit_wr_o   (tb1_wr),
      .bit_idx_o  (tb1_idx)
   );

   vd_output_buf obuf_inst (
      .clk         (clk),
      .rst         (rst),
      .bit0_i      (tb0_bit),
      .bit0_wr_i   (tb0_wr),
      .bit0_idx_i  (tb0_idx),
      .bit1_i      (tb1_bit),
      .bit1_wr_i   (tb1_wr),
      .bit1_idx_i  (tb1_idx),
      .d_out_o     (d_out_o),
      .out_valid_o (out_valid_o)
   );

endmodule

// ==== testbench/vd_decoder_chk.sv ====
`timescale 1ns/1ps

module vd_decoder_chk (
   input logic clk,
   input logic rst,
   input logic d_out_i,
   input logic out_valid_i
);

   // Async reset clears the output level
   assert property (@(posedge clk) !rst |=> !out_valid_i)
      else $error("out_valid_o not low during reset");

   // Output stream never stops once started
   assert property (@(posedge clk) disable iff (!rst) out_valid_i |=> out_valid_i)
      else $error("out_valid_o dropped without reset");

   assert property (@(posedge clk) disable iff (!rst) out_valid_i |-> !$isunknown(d_out_i))
      else $error("d_out_o unknown while out_valid_o is high");

endmodule

bind vd_decoder_top vd_decoder_chk chk_inst (
   .clk         (clk),
   .rst         (rst),
   .d_out_i     (d_out_o),
   .out_valid_i (out_valid_o)
);

// ==== testbench/vd_decoder_tb.sv ====
`timescale 1ns/1ps
`include "vd_config.svh"

module vd_decoder_tb;
   import vd_pkg::*;

   typedef enum int {PAT_RANDOM, PAT_ZEROS, PAT_ONES} pattern_e;

   localparam int NUM_ROWS  = 5;
   localparam int FLUSH_LEN = 64;
   localparam int SLACK     = 100;

   localparam logic [3:0] G0 = `VD_G0;
   localparam logic [3:0] G1 = `VD_G1;

   // Rows hold name, info length, data pattern, error spacing and expected bit count
   string    row_name    [NUM_ROWS] = '{"random_clean", "random_errors", "all_zeros",
                                        "all_ones", "long_norm"};
   int       row_len     [NUM_ROWS] = '{300, 300, 200, 200, 4000};
   pattern_e row_pattern [NUM_ROWS] = '{PAT_RANDOM, PAT_RANDOM, PAT_ZEROS,
                                        PAT_ONES, PAT_RANDOM};
   int       row_spacing [NUM_ROWS] = '{0, 12, 0, 0, 12};
   int       row_exp_cnt [NUM_ROWS] = '{300, 300, 200, 200, 4000};

   logic        clk = 1'b0;
   logic        rst;
   sym_t        d_in_i;
   logic        d_out_o;
   logic        out_valid_o;
   int unsigned lcg_state = 41953;

   always #2 clk = ~clk;

   vd_decoder_top vd_decoder_top_inst (
      .clk         (clk),
      .rst         (rst),
      .d_in_i      (d_in_i),
      .d_out_o     (d_out_o),
      .out_valid_o (out_valid_o)
   );

   function automatic logic lcg_bit();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[16];
   endfunction

   // Reference encoder over r = {u, s} with bit 3 as the input bit
   function automatic sym_t encode_symbol(input logic u, input state_t s);
      logic c0;
      logic c1;
      c0 = (G0[3] & u) ^ (G0[2] & s[2]) ^ (G0[1] & s[1]) ^ (G0[0] & s[0]);
      c1 = (G1[3] & u) ^ (G1[2] & s[2]) ^ (G1[1] & s[1]) ^ (G1[0] & s[0]);
      return {c1, c0};
   endfunction

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("Error: %s expected %0b actual %0b", what, exp, act);
         $display("Regression failed");
         $fatal(1, "Bit mismatch");
      end
   endtask

   task automatic check_count(input string what, input int exp, input int act);
      if (act != exp)
      begin
         $display("Error: %s expected %0d actual %0d", what, exp, act);
         $display("Regression failed");
         $fatal(1, "Count mismatch");
      end
   endtask

   task automatic run_row(input int row);
      logic   info_bits [$];
      state_t enc_state;
      sym_t   sym;
      logic   u;
      int     len;
      int     fed;
      int     n_out;
      int     n_cmp;
      int     cap;
      len = row_len[row];
      cap = len + FLUSH_LEN + 80;
      info_bits.delete();
      for (int k = 0; k < len; k++)
      begin
         case (row_pattern[row])
            PAT_ZEROS: info_bits.push_back(1'b0);
            PAT_ONES:  info_bits.push_back(1'b1);
            default:   info_bits.push_back(lcg_bit());
         endcase
      end

      @(negedge clk);
      rst    = 1'b0;
      d_in_i = '0;
      repeat (4) @(negedge clk);
      check_bit($sformatf("%s out_valid in reset", row_name[row]), 1'b0, out_valid_o);
      rst       = 1'b1;
      enc_state = '0;
      fed       = 0;
      n_out     = 0;
      n_cmp     = 0;

      for (int cyc = 0; cyc < cap; cyc++)
      begin
         // Outputs settled since the last rising edge
         if (out_valid_o)
         begin
            if (n_out < len)
            begin
               check_bit($sformatf("%s bit %0d", row_name[row], n_out),
                         info_bits[n_out], d_out_o);
               n_cmp++;
            end
            n_out++;
         end
         if (n_cmp == len && fed >= len + FLUSH_LEN)
            break;
         // Flush and idle symbols carry zero bits
         u         = (fed < len) ? info_bits[fed] : 1'b0;
         sym       = encode_symbol(u, enc_state);
         enc_state = {u, enc_state[2:1]};
         if (row_spacing[row] != 0 && fed < len + FLUSH_LEN &&
             (fed + 1) % row_spacing[row] == 0)
            sym = sym ^ (lcg_bit() ? sym_t'(2'b10) : sym_t'(2'b01));
         d_in_i = sym;
         fed++;
         @(negedge clk);
      end
      check_count($sformatf("%s decoded count", row_name[row]), row_exp_cnt[row], n_cmp);
   endtask

   initial
   begin
      rst    = 1'b0;
      d_in_i = '0;
      for (int i = 0; i < NUM_ROWS; i++)
         run_row(i);
      $display("Regression passed");
      $finish;
   end

   // Watchdog sized from the table
   initial
   begin
      int unsigned limit_cycles;
      limit_cycles = 0;
      for (int i = 0; i < NUM_ROWS; i++)
         limit_cycles += row_len[i] + FLUSH_LEN + SLACK;
      #(limit_cycles * 4);
      $display("Run did not finish within %0d clock cycles", limit_cycles);
      $display("Regression failed");
      $fatal(1, "Watchdog timeout");
   end

endmodule

// ==== build.f ====
+incdir+include
design/vd_pkg.sv
design/vd_mem_rd_if.sv
design/vd_ram.sv
design/vd_branch_metric.sv
design/vd_acs_array.sv
design/vd_survivor_mem.sv
design/vd_traceback_unit.sv
design/vd_output_buf.sv
design/vd_decoder_top.sv
testbench/vd_decoder_chk.sv
testbench/vd_decoder_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the Viterbi decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   -f build.f \
   --top-module vd_decoder_tb \
   -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/Vvd_decoder_tb
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation ended with status $status"
   exit $status
fi

exit 0
